/* sim_shell.f */
src/shell_pkg.sv
src/axil_if.sv
src/req_if.sv
src/req_arbiter.sv
src/req_to_axil.sv
src/delayed_axil_slave.sv
src/sim_shell_top.sv
verif/tb_clock_gen.sv
verif/tb_sim_shell.sv

/* src/axil_if.sv */
////////////////////////////////////////////////////////////
// AXI4-Lite bus, single beats only
// master and slave views
////////////////////////////////////////////////////////////

interface axil_if import shell_pkg::*; ();

    // read address
    logic [ADDR_W-1:0] araddr;
    logic              arvalid;
    logic              arready;

    // read data
    logic [DATA_W-1:0] rdata;
    axil_resp_t        rresp;
    logic              rvalid;
    logic              rready;

    // write address and data, presented together by the bridge
    logic [ADDR_W-1:0] awaddr;
    logic              awvalid;
    logic              awready;
    logic [DATA_W-1:0] wdata;
    logic [BE_W-1:0]   wstrb;
    logic              wvalid;
    logic              wready;

    // write response
    axil_resp_t        bresp;
    logic              bvalid;
    logic              bready;

    modport master (
        output araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
        input  arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
    );

    modport slave (
        input  araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
        output arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
    );

endinterface

/* src/delayed_axil_slave.sv */
////////////////////////////////////////////////////////////
// slow AXI4-Lite target, fixed countdown per access
// word scratch memory and UART byte capture
////////////////////////////////////////////////////////////

module delayed_axil_slave
    import shell_pkg::*;
#(
    parameter int RESP_DELAY    = 5,
    parameter int SCRATCH_WORDS = 256
) (
    input  logic       clk,
    input  logic       rst,
    axil_if.slave      bus,
    output logic       uart_valid,
    output logic [7:0] uart_byte
);

    localparam int IDX_W = (SCRATCH_WORDS > 1) ? $clog2(SCRATCH_WORDS) : 1;
    localparam int CNT_W = $clog2(RESP_DELAY + 1);

    slave_state_t     state;
    logic [CNT_W-1:0] count;

    logic [DATA_W-1:0] mem [SCRATCH_WORDS];

    // latched access
    logic              rnw_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic [BE_W-1:0]   wstrb_q;

    // decoded result
    logic [DATA_W-1:0] rdata_q;
    axil_resp_t        resp_q;

    logic             rd_accept;
    logic             wr_accept;
    logic             is_scratch;
    logic             is_uart;
    logic [IDX_W-1:0] word_idx;

    // reads win if both show up, the bridge never does that
    assign rd_accept = bus.arvalid & bus.arready;
    assign wr_accept = ~rd_accept & bus.awvalid & bus.awready & bus.wvalid & bus.wready;

    // address decode on the latched address
    assign is_scratch = (addr_q[ADDR_W-1:2] < SCRATCH_WORDS);
    assign is_uart    = (addr_q == UART_ADDR);
    assign word_idx   = addr_q[2 +: IDX_W];

    ////////////////////////////////////////////////////////////
    // state machine

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SL_IDLE;
            count <= '0;
        end else begin
            case (state)
                SL_IDLE: begin
                    if (rd_accept || wr_accept) begin
                        state <= SL_COUNT;
                        count <= CNT_W'(RESP_DELAY - 1);
                    end
                end
                SL_COUNT: begin
                    if (count == '0) begin
                        state <= SL_RESPOND;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                SL_RESPOND: begin
                    if ((bus.rvalid && bus.rready) || (bus.bvalid && bus.bready)) begin
                        state <= SL_IDLE;
                    end
                end
                default: state <= SL_IDLE;
            endcase
        end
    end

    // access capture
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rnw_q  <= 1'b1;
            addr_q <= bus.araddr;
        end else if (wr_accept) begin
            rnw_q   <= 1'b0;
            addr_q  <= bus.awaddr;
            wdata_q <= bus.wdata;
            wstrb_q <= bus.wstrb;
        end
    end

    // decode and memory access at the end of the count
    always_ff @(posedge clk) begin
        if (state == SL_COUNT && count == '0) begin
            resp_q <= (is_scratch || is_uart) ? OKAY : SLVERR;
            if (rnw_q) begin
                rdata_q <= is_scratch ? mem[word_idx] : '0;
            end else begin
                rdata_q <= '0;
                // byte merge by strobe
                for (int i = 0; i < BE_W; i++) begin
                    if (is_scratch && wstrb_q[i]) begin
                        mem[word_idx][8*i +: 8] <= wdata_q[8*i +: 8];
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // UART capture, one cycle after the write handshake

    always_ff @(posedge clk) begin
        if (rst) begin
            uart_valid <= 1'b0;
        end else begin
            uart_valid <= wr_accept & (bus.awaddr == UART_ADDR);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept && bus.awaddr == UART_ADDR) begin
            uart_byte <= bus.wdata[7:0];
        end
    end

    // bus outputs
    assign bus.arready = (state == SL_IDLE);
    assign bus.awready = (state == SL_IDLE);
    assign bus.wready  = (state == SL_IDLE);
    assign bus.rvalid  = (state == SL_RESPOND) & rnw_q;
    assign bus.bvalid  = (state == SL_RESPOND) & ~rnw_q;
    assign bus.rdata   = rdata_q;
    assign bus.rresp   = resp_q;
    assign bus.bresp   = resp_q;

endmodule

/* src/req_arbiter.sv */
////////////////////////////////////////////////////////////
// round-robin arbiter for two requester ports
// responses routed back by tag
////////////////////////////////////////////////////////////

module req_arbiter
    import shell_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    // requester port 0
    input  logic              p0_req_valid,
    output logic              p0_req_ready,
    input  logic              p0_rnw,
    input  logic [ADDR_W-1:0] p0_addr,
    input  logic [BE_W-1:0]   p0_be,
    input  logic [DATA_W-1:0] p0_wdata,
    output logic              p0_rsp_valid,
    input  logic              p0_rsp_ready,
    output logic [DATA_W-1:0] p0_rdata,
    output logic              p0_rsp_err,

    // requester port 1
    input  logic              p1_req_valid,
    output logic              p1_req_ready,
    input  logic              p1_rnw,
    input  logic [ADDR_W-1:0] p1_addr,
    input  logic [BE_W-1:0]   p1_be,
    input  logic [DATA_W-1:0] p1_wdata,
    output logic              p1_rsp_valid,
    input  logic              p1_rsp_ready,
    output logic [DATA_W-1:0] p1_rdata,
    output logic              p1_rsp_err,

    // shared link to the bridge
    req_if.arb                down
);

    // port granted on the last accepted request
    logic last_grant;
    // port that wins this cycle
    logic grant_sel;

    ////////////////////////////////////////////////////////////
    // request side

    // tie goes to the port not served last time
    always_comb begin
        if (p0_req_valid && p1_req_valid) begin
            grant_sel = ~last_grant;
        end else begin
            grant_sel = p1_req_valid;
        end
    end

    assign down.valid = p0_req_valid | p1_req_valid;
    assign down.tag   = grant_sel;
    assign down.rnw   = grant_sel ? p1_rnw   : p0_rnw;
    assign down.addr  = grant_sel ? p1_addr  : p0_addr;
    assign down.be    = grant_sel ? p1_be    : p0_be;
    assign down.wdata = grant_sel ? p1_wdata : p0_wdata;

    // only the winner sees ready
    assign p0_req_ready = down.ready & p0_req_valid & ~grant_sel;
    assign p1_req_ready = down.ready & p1_req_valid & grant_sel;

    // start with port 0 favoured
    always_ff @(posedge clk) begin
        if (rst) begin
            last_grant <= 1'b1;
        end else if (down.valid && down.ready) begin
            last_grant <= grant_sel;
        end
    end

    ////////////////////////////////////////////////////////////
    // response side

    assign p0_rsp_valid = down.rsp_valid & ~down.rsp_tag;
    assign p1_rsp_valid = down.rsp_valid & down.rsp_tag;

    // payload shared, valid qualifies it
    assign p0_rdata   = down.rdata;
    assign p1_rdata   = down.rdata;
    assign p0_rsp_err = down.rsp_err;
    assign p1_rsp_err = down.rsp_err;

    assign down.rsp_ready = down.rsp_tag ? p1_rsp_ready : p0_rsp_ready;

endmodule

/* src/req_if.sv */
////////////////////////////////////////////////////////////
// tagged request/response link, arbiter to bridge
////////////////////////////////////////////////////////////

interface req_if import shell_pkg::*; ();

    // request, tag is the requester port number
    logic              valid;
    logic              ready;
    logic              rnw;
    logic [ADDR_W-1:0] addr;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] wdata;
    logic              tag;

    // response, tag steers it back
    logic              rsp_valid;
    logic              rsp_ready;
    logic              rsp_tag;
    logic [DATA_W-1:0] rdata;
    logic              rsp_err;

    modport arb (
        output valid, rnw, addr, be, wdata, tag, rsp_ready,
        input  ready, rsp_valid, rsp_tag, rdata, rsp_err
    );

    modport bridge (
        input  valid, rnw, addr, be, wdata, tag, rsp_ready,
        output ready, rsp_valid, rsp_tag, rdata, rsp_err
    );

endinterface

/* src/req_to_axil.sv */
////////////////////////////////////////////////////////////
// request to AXI4-Lite bridge
// one transaction in flight, result returned with its tag
////////////////////////////////////////////////////////////

module req_to_axil
    import shell_pkg::*;
(
    input  logic clk,
    input  logic rst,
    req_if.bridge up,
    axil_if.master bus
);

    bridge_state_t state;

    // latched request
    logic              rnw_q;
    logic [ADDR_W-1:0] addr_q;
    logic [BE_W-1:0]   be_q;
    logic [DATA_W-1:0] wdata_q;
    logic              tag_q;

    // captured result
    logic [DATA_W-1:0] rdata_q;
    logic              err_q;

    // address phase done on the bus
    logic addr_done;

    assign addr_done = rnw_q ? (bus.arvalid & bus.arready)
                             : (bus.awvalid & bus.awready & bus.wvalid & bus.wready);

    ////////////////////////////////////////////////////////////
    // state machine

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= BR_IDLE;
        end else begin
            case (state)
                BR_IDLE: begin
                    if (up.valid) begin
                        state <= BR_ADDR;
                    end
                end
                // stalls here while the target is busy
                BR_ADDR: begin
                    if (addr_done) begin
                        state <= BR_RESP;
                    end
                end
                BR_RESP: begin
                    if ((bus.rvalid && bus.rready) || (bus.bvalid && bus.bready)) begin
                        state <= BR_DONE;
                    end
                end
                // held until the requester takes it
                BR_DONE: begin
                    if (up.rsp_ready) begin
                        state <= BR_IDLE;
                    end
                end
                default: state <= BR_IDLE;
            endcase
        end
    end

    // request capture on accept
    always_ff @(posedge clk) begin
        if (state == BR_IDLE && up.valid) begin
            rnw_q   <= up.rnw;
            addr_q  <= up.addr;
            be_q    <= up.be;
            wdata_q <= up.wdata;
            tag_q   <= up.tag;
        end
    end

    // result capture, writes return zero data
    always_ff @(posedge clk) begin
        if (bus.rvalid && bus.rready) begin
            rdata_q <= bus.rdata;
            err_q   <= (bus.rresp == SLVERR);
        end else if (bus.bvalid && bus.bready) begin
            rdata_q <= '0;
            err_q   <= (bus.bresp == SLVERR);
        end
    end

    ////////////////////////////////////////////////////////////
    // outputs

    assign up.ready     = (state == BR_IDLE);
    assign up.rsp_valid = (state == BR_DONE);
    assign up.rsp_tag   = tag_q;
    assign up.rdata     = rdata_q;
    assign up.rsp_err   = err_q;

    // read or combined address and write
    assign bus.arvalid = (state == BR_ADDR) & rnw_q;
    assign bus.awvalid = (state == BR_ADDR) & ~rnw_q;
    assign bus.wvalid  = (state == BR_ADDR) & ~rnw_q;
    assign bus.araddr  = addr_q;
    assign bus.awaddr  = addr_q;
    assign bus.wdata   = wdata_q;
    assign bus.wstrb   = be_q;

    assign bus.rready = (state == BR_RESP) & rnw_q;
    assign bus.bready = (state == BR_RESP) & ~rnw_q;

endmodule

/* src/shell_pkg.sv */
////////////////////////////////////////////////////////////
// shared widths and the UART capture address
// AXI4-Lite response codes
// bridge and target state encodings
////////////////////////////////////////////////////////////

package shell_pkg;

    ////////////////////////////////////////////////////////////
    // widths

    // byte address
    localparam int ADDR_W = 32;
    // data word
    localparam int DATA_W = 32;
    // one strobe per byte lane
    localparam int BE_W = DATA_W / 8;

    // write here shows up as a console byte
    // sits above the default scratch range
    localparam logic [ADDR_W-1:0] UART_ADDR = 32'h0000_1000;

    ////////////////////////////////////////////////////////////
    // encodings

    // only the two codes the target can return
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_t;

    // request to bus bridge
    typedef enum logic [1:0] {
        BR_IDLE = 2'd0,
        BR_ADDR = 2'd1,
        BR_RESP = 2'd2,
        BR_DONE = 2'd3
    } bridge_state_t;

    // slow target model
    typedef enum logic [1:0] {
        SL_IDLE    = 2'd0,
        SL_COUNT   = 2'd1,
        SL_RESPOND = 2'd2
    } slave_state_t;

endpackage

/* src/sim_shell_top.sv */
////////////////////////////////////////////////////////////
// simulation shell top level
// two requester ports, arbiter, bridge, slow bus target
////////////////////////////////////////////////////////////

module sim_shell_top
    import shell_pkg::*;
#(
    parameter int RESP_DELAY    = 5,
    parameter int SCRATCH_WORDS = 256
) (
    input  logic              clk,
    input  logic              rst,

    // port 0
    input  logic              p0_req_valid,
    output logic              p0_req_ready,
    input  logic              p0_rnw,
    input  logic [ADDR_W-1:0] p0_addr,
    input  logic [BE_W-1:0]   p0_be,
    input  logic [DATA_W-1:0] p0_wdata,
    output logic              p0_rsp_valid,
    input  logic              p0_rsp_ready,
    output logic [DATA_W-1:0] p0_rdata,
    output logic              p0_rsp_err,

    // port 1
    input  logic              p1_req_valid,
    output logic              p1_req_ready,
    input  logic              p1_rnw,
    input  logic [ADDR_W-1:0] p1_addr,
    input  logic [BE_W-1:0]   p1_be,
    input  logic [DATA_W-1:0] p1_wdata,
    output logic              p1_rsp_valid,
    input  logic              p1_rsp_ready,
    output logic [DATA_W-1:0] p1_rdata,
    output logic              p1_rsp_err,

    // console byte capture
    output logic              uart_valid,
    output logic [7:0]        uart_byte
);

    // arbiter to bridge
    req_if req_link ();
    // bridge to target
    axil_if axil_link ();

    req_arbiter u_arb (
        .clk,
        .rst,
        .p0_req_valid, .p0_req_ready, .p0_rnw, .p0_addr, .p0_be, .p0_wdata,
        .p0_rsp_valid, .p0_rsp_ready, .p0_rdata, .p0_rsp_err,
        .p1_req_valid, .p1_req_ready, .p1_rnw, .p1_addr, .p1_be, .p1_wdata,
        .p1_rsp_valid, .p1_rsp_ready, .p1_rdata, .p1_rsp_err,
        .down (req_link)
    );

    req_to_axil u_bridge (
        .clk,
        .rst,
        .up  (req_link),
        .bus (axil_link)
    );

    delayed_axil_slave #(
        .RESP_DELAY    (RESP_DELAY),
        .SCRATCH_WORDS (SCRATCH_WORDS)
    ) u_periph (
        .clk,
        .rst,
        .bus (axil_link),
        .uart_valid,
        .uart_byte
    );

endmodule

/* verif/tb_clock_gen.sv */
////////////////////////////////////////////////////////////
// testbench clock and reset source
////////////////////////////////////////////////////////////

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    // period 10
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held for 5 cycles, released just after an edge
    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

/* verif/tb_sim_shell.sv */
////////////////////////////////////////////////////////////
// directed tests for the simulation shell
// reference scratch model, grant and UART monitors
////////////////////////////////////////////////////////////

module tb_sim_shell
    import shell_pkg::*;
();

    localparam int SCRATCH_WORDS = 256;
    localparam int IDX_W         = $clog2(SCRATCH_WORDS);
    localparam int TIMEOUT       = 200;
    localparam int SEED          = 43549;

    logic clk;
    logic rst;

    logic              p0_req_valid, p0_req_ready, p0_rnw, p0_rsp_valid, p0_rsp_ready, p0_rsp_err;
    logic [ADDR_W-1:0] p0_addr;
    logic [BE_W-1:0]   p0_be;
    logic [DATA_W-1:0] p0_wdata, p0_rdata;
    logic              p1_req_valid, p1_req_ready, p1_rnw, p1_rsp_valid, p1_rsp_ready, p1_rsp_err;
    logic [ADDR_W-1:0] p1_addr;
    logic [BE_W-1:0]   p1_be;
    logic [DATA_W-1:0] p1_wdata, p1_rdata;
    logic              uart_valid;
    logic [7:0]        uart_byte;

    // mirror of the scratch memory, X until written like the DUT
    logic [DATA_W-1:0] ref_mem [SCRATCH_WORDS];
    int                grant_log [$];
    int                uart_pulses;
    logic [7:0]        uart_seen;

    tb_clock_gen u_clock_gen (.clk, .rst);

    sim_shell_top u_sim_shell_top (.*);

    ////////////////////////////////////////////////////////////
    // monitors, sampled mid-cycle

    // a grant is valid and ready together
    always @(negedge clk) begin
        if (p0_req_valid && p0_req_ready) grant_log.push_back(0);
        if (p1_req_valid && p1_req_ready) grant_log.push_back(1);
    end

    always @(negedge clk) begin
        if (!rst && uart_valid) begin
            uart_pulses++;
            uart_seen = uart_byte;
        end
    end

    ////////////////////////////////////////////////////////////
    // checks and helpers

    task automatic check_eq(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
        assert (got === exp) else begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timed out waiting for %s", what);
        $display("CHECKS FAILED");
        $fatal(1, "timeout");
    endtask

    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
                                                      input logic [DATA_W-1:0] data,
                                                      input logic [BE_W-1:0] be);
        logic [DATA_W-1:0] res;
        res = old;
        for (int i = 0; i < BE_W; i++) begin
            if (be[i]) res[8*i +: 8] = data[8*i +: 8];
        end
        return res;
    endfunction

    // raise a request, fields held until accepted
    task automatic drive_req(input int port, input logic rnw, input logic [ADDR_W-1:0] addr,
                             input logic [BE_W-1:0] be, input logic [DATA_W-1:0] wdata);
        if (port == 1) begin
            p1_req_valid = 1'b1;
            p1_rnw       = rnw;
            p1_addr      = addr;
            p1_be        = be;
            p1_wdata     = wdata;
        end else begin
            p0_req_valid = 1'b1;
            p0_rnw       = rnw;
            p0_addr      = addr;
            p0_be        = be;
            p0_wdata     = wdata;
        end
    endtask

    // wait for ready, then drop valid after the handshake edge
    task automatic finish_req(input int port);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!((port == 1) ? p1_req_ready : p0_req_ready)) begin
            waited++;
            if (waited > TIMEOUT) timeout_fail("request ready");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        if (port == 1) p1_req_valid = 1'b0;
        else p0_req_valid = 1'b0;
    endtask

    task automatic wait_rsp_valid(input int port);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!((port == 1) ? p1_rsp_valid : p0_rsp_valid)) begin
            waited++;
            if (waited > TIMEOUT) timeout_fail("response valid");
            @(negedge clk);
        end
    endtask

    // rsp_ready high, so the handshake is the next edge
    task automatic wait_rsp(input int port, output logic [DATA_W-1:0] rdata, output logic err);
        wait_rsp_valid(port);
        rdata = (port == 1) ? p1_rdata : p0_rdata;
        err   = (port == 1) ? p1_rsp_err : p0_rsp_err;
        @(posedge clk);
        #1;
    endtask

    task automatic do_access(input int port, input logic rnw, input logic [ADDR_W-1:0] addr,
                             input logic [BE_W-1:0] be, input logic [DATA_W-1:0] wdata,
                             output logic [DATA_W-1:0] rdata, output logic err);
        drive_req(port, rnw, addr, be, wdata);
        finish_req(port);
        // model follows scratch writes only
        if (!rnw && addr[ADDR_W-1:2] < SCRATCH_WORDS) begin
            ref_mem[addr[2 +: IDX_W]] = merge_bytes(ref_mem[addr[2 +: IDX_W]], wdata, be);
        end
        wait_rsp(port, rdata, err);
    endtask

    task automatic write_ok(input int port, input logic [ADDR_W-1:0] addr,
                            input logic [BE_W-1:0] be, input logic [DATA_W-1:0] wdata);
        logic [DATA_W-1:0] rdata;
        logic              err;
        do_access(port, 1'b0, addr, be, wdata, rdata, err);
        check_eq("rsp_err", err, 0);
    endtask

    task automatic check_read(input int port, input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] rdata;
        logic              err;
        do_access(port, 1'b1, addr, '0, '0, rdata, err);
        check_eq("rsp_err", err, 0);
        check_eq($sformatf("p%0d_rdata", port), rdata, ref_mem[addr[2 +: IDX_W]]);
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests

    task automatic scratch_rw_test();
        write_ok(0, 32'h10, 4'hf, 32'hA5A5_1234);
        write_ok(0, 32'h10, 4'b0101, 32'h5A5A_CDEF);
        write_ok(0, 32'h14, 4'hf, 32'h0BAD_CAFE);
        check_read(0, 32'h10);
    endtask

    task automatic uart_test();
        // word 0 is where the UART address would alias in scratch
        write_ok(0, 32'h0, 4'hf, 32'h1357_9BDF);
        uart_pulses = 0;
        drive_req(1, 1'b0, UART_ADDR, 4'hf, 32'h0000_0C41);
        finish_req(1);
        // pulse lands before the response
        wait_rsp_valid(1);
        check_eq("uart_pulses", uart_pulses, 1);
        check_eq("uart_byte", uart_seen, 8'h41);
        check_eq("p1_rsp_err", p1_rsp_err, 0);
        @(posedge clk);
        #1;
        // scratch untouched
        check_read(1, 32'h0);
        check_read(1, 32'h10);
        check_read(1, 32'h14);
        // no second pulse later on
        check_eq("uart_pulses", uart_pulses, 1);
    endtask

    task automatic decode_err_test();
        logic [DATA_W-1:0] rdata;
        logic              err;
        do_access(0, 1'b1, 32'h2000, '0, '0, rdata, err);
        check_eq("rsp_err", err, 1);
        check_eq("p0_rdata", rdata, 0);
        do_access(1, 1'b0, 32'h2000, 4'hf, 32'hDEAD_BEEF, rdata, err);
        check_eq("rsp_err", err, 1);
        // failed write must not alias into word 0
        check_read(0, 32'h0);
    endtask

    task automatic arbitration_test();
        grant_log.delete();
        fork
            begin
                for (int i = 0; i < 4; i++) write_ok(0, (32 + i) * 4, 4'hf, 32'hA000_0000 + i);
            end
            begin
                for (int i = 0; i < 4; i++) write_ok(1, (40 + i) * 4, 4'hf, 32'hB000_0000 + i);
            end
        join
        check_eq("grant count", grant_log.size(), 8);
        // winner flips on every grant
        for (int i = 1; i < grant_log.size(); i++) begin
            check_eq("grant port", grant_log[i], 1 - grant_log[i-1]);
        end
        for (int i = 0; i < 4; i++) begin
            check_read(0, (32 + i) * 4);
            check_read(1, (40 + i) * 4);
        end
    endtask

    task automatic backpressure_test();
        logic [DATA_W-1:0] held;
        logic [DATA_W-1:0] rdata;
        logic              err;
        int                stall;
        stall = $urandom_range(20, 1);
        p0_rsp_ready = 1'b0;
        drive_req(0, 1'b1, 32'h10, '0, '0);
        finish_req(0);
        // port 1 queues behind the stalled response
        drive_req(1, 1'b0, 32'h18, 4'hf, 32'h600D_F00D);
        ref_mem[6] = 32'h600D_F00D;
        wait_rsp_valid(0);
        held = p0_rdata;
        check_eq("p0_rdata", held, ref_mem[4]);
        for (int i = 0; i < stall; i++) begin
            @(negedge clk);
            check_eq("p0_rsp_valid", p0_rsp_valid, 1);
            check_eq("p0_rdata", p0_rdata, held);
            check_eq("p1_req_ready", p1_req_ready, 0);
        end
        @(posedge clk);
        #1;
        p0_rsp_ready = 1'b1;
        @(negedge clk);
        check_eq("p0_rsp_valid", p0_rsp_valid, 1);
        check_eq("p1_req_ready", p1_req_ready, 0);
        finish_req(1);
        wait_rsp(1, rdata, err);
        check_eq("rsp_err", err, 0);
        check_read(0, 32'h18);
    endtask

    task automatic random_test();
        int                port;
        logic              rnw;
        logic [ADDR_W-1:0] addr;
        // every word in the window gets a known value first
        for (int w = 0; w < 32; w++) begin
            write_ok(w % 2, w * 4, 4'hf, $urandom);
        end
        for (int n = 0; n < 40; n++) begin
            port = $urandom_range(1, 0);
            rnw  = $urandom_range(1, 0);
            // small window so reads hit written words
            addr = $urandom_range(31, 0) * 4;
            if (rnw) check_read(port, addr);
            else write_ok(port, addr, $urandom_range(15, 0), $urandom);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        int waited;
        p0_req_valid = 1'b0;
        p0_rnw       = 1'b0;
        p0_addr      = '0;
        p0_be        = '0;
        p0_wdata     = '0;
        p0_rsp_ready = 1'b1;
        p1_req_valid = 1'b0;
        p1_rnw       = 1'b0;
        p1_addr      = '0;
        p1_be        = '0;
        p1_wdata     = '0;
        p1_rsp_ready = 1'b1;
        uart_pulses  = 0;
        void'($urandom(SEED));
        waited       = 0;
        @(negedge clk);
        while (rst) begin
            waited++;
            if (waited > TIMEOUT) timeout_fail("reset release");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        scratch_rw_test();
        uart_test();
        decode_err_test();
        arbitration_test();
        backpressure_test();
        random_test();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
